/* Bender.yml */
package:
  name: ntm_vector_summation

dependencies: {}

export_include_dirs:
  - hdl

sources:
  # Design, in compile order
  - include_dirs:
      - hdl
    files:
      - hdl/ntm_summation_pkg.sv
      - hdl/ntm_summation_dispatcher.sv
      - hdl/ntm_summation_lane.sv
      - hdl/ntm_summation_collector.sv
      - hdl/ntm_vector_summation.sv

  # Testbench
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/ntm_vector_summation_tb.sv

/* hdl/ntm_summation_collector.sv */
// Collector of the vector summation unit; reads the lane sums out serially and pulses ready
`timescale 1ns/1ns
`default_nettype none

`include "ntm_summation_macros.svh"

module ntm_summation_collector
  import ntm_summation_pkg::*;
(
  input  wire logic       CLK,
  input  wire logic       RST,
  input  wire drain_cmd_t drain,
  input  wire data_t      lane_sums [`NTM_LANES],
  output logic            data_out_enable,
  output data_t           data_out,
  output logic            ready
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Drain in progress
  logic draining;

  // Next lane to read
  lane_idx_t rd_idx;

  // Lanes in this job
  count_t len_q;

  logic rd_last;

  // Final lane of the job
  assign rd_last = (count_t'(rd_idx) == len_q - count_t'(1));

  ////////////////////////////////////////
  // Drain control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      draining        <= 1'b0;
      rd_idx          <= '0;
      len_q           <= '0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
    end else begin
      if (draining) begin
        // One lane per cycle
        data_out_enable <= 1'b1;
        ready           <= rd_last;
        if (rd_last) begin
          draining <= 1'b0;
          rd_idx   <= '0;
        end else begin
          rd_idx <= rd_idx + lane_idx_t'(1);
        end
      end else begin
        data_out_enable <= 1'b0;
        ready           <= 1'b0;
        if (drain.valid) begin
          // Lanes settle one cycle after the last element
          draining <= 1'b1;
          rd_idx   <= '0;
          len_q    <= drain.length;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Output data
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (draining) begin
      data_out <= lane_sums[rd_idx];
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Ready marks the final strobe, the burst ends right after
  a_ready_last : assert property (
    @(posedge CLK) disable iff (RST)
    ready |-> data_out_enable ##1 !data_out_enable
  );

endmodule

`default_nettype wire

/* hdl/ntm_summation_dispatcher.sv */
// Dispatcher of the vector summation unit; captures a job, routes elements to lanes, drains
`timescale 1ns/1ns
`default_nettype none

`include "ntm_summation_macros.svh"

module ntm_summation_dispatcher
  import ntm_summation_pkg::*;
(
  input  wire logic   CLK,
  input  wire logic   RST,
  input  wire logic   START,
  input  wire count_t size_in,
  input  wire count_t length_in,
  input  wire logic   data_in_enable,
  input  wire data_t  data_in,
  output logic        busy,
  output lane_cmd_t   lane_cmd,
  output drain_cmd_t  drain
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  dispatch_state_t state;

  // Captured job shape
  count_t size_q;
  count_t len_q;

  // Position inside the job
  count_t elem_idx;
  count_t vec_idx;

  // Cycles left until the collector has pulsed READY
  count_t drain_wait;

  logic start_ok;
  logic last_elem;
  logic last_vec;

  ////////////////////////////////////////
  // Job acceptance
  ////////////////////////////////////////

  // Refused while busy or with an empty or oversized shape
  assign start_ok = START && !busy &&
                    (size_in != '0) &&
                    (length_in != '0) &&
                    (length_in <= count_t'(`NTM_LANES));

  assign last_elem = (elem_idx == len_q - count_t'(1));
  assign last_vec  = (vec_idx == size_q - count_t'(1));

  ////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= IDLE_STATE;
      busy       <= 1'b0;
      size_q     <= '0;
      len_q      <= '0;
      elem_idx   <= '0;
      vec_idx    <= '0;
      drain_wait <= '0;
      lane_cmd   <= '0;
      drain      <= '0;
    end else begin
      // Strobes last one cycle
      lane_cmd.valid <= 1'b0;
      drain.valid    <= 1'b0;

      case (state)
        IDLE_STATE: begin
          if (start_ok) begin
            size_q   <= size_in;
            len_q    <= length_in;
            elem_idx <= '0;
            vec_idx  <= '0;
            busy     <= 1'b1;
            state    <= INPUT_STATE;
          end else if (drain_wait != '0) begin
            // Busy falls at the edge that ends the READY cycle
            drain_wait <= drain_wait - count_t'(1);
            if (drain_wait == count_t'(1)) begin
              busy <= 1'b0;
            end
          end
        end

        INPUT_STATE: begin
          if (data_in_enable) begin
            // Element index selects the lane
            lane_cmd.valid <= 1'b1;
            lane_cmd.clear <= (vec_idx == '0);
            lane_cmd.lane  <= elem_idx[`NTM_LANE_IDX_WIDTH-1:0];
            lane_cmd.data  <= data_in;

            if (last_elem) begin
              elem_idx <= '0;
              if (last_vec) begin
                // Last element of the job
                drain.valid  <= 1'b1;
                drain.length <= len_q;
                // Lane update, drain start, then len_q outputs
                drain_wait   <= len_q + count_t'(2);
                state        <= IDLE_STATE;
              end else begin
                vec_idx <= vec_idx + count_t'(1);
              end
            end else begin
              elem_idx <= elem_idx + count_t'(1);
            end
          end
        end

        default: begin
          state <= IDLE_STATE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Routed lane stays inside the captured vector length
  a_lane_in_range : assert property (
    @(posedge CLK) disable iff (RST)
    lane_cmd.valid |-> (count_t'(lane_cmd.lane) < len_q)
  );

  // Unit stays busy across the drain, and one drain per job
  a_drain_busy : assert property (
    @(posedge CLK) disable iff (RST)
    drain.valid |=> (busy && !drain.valid)
  );

endmodule

`default_nettype wire

/* hdl/ntm_summation_lane.sv */
// One saturating accumulator lane of the vector summation unit; instanced once per position
`timescale 1ns/1ns
`default_nettype none

`include "ntm_summation_macros.svh"

module ntm_summation_lane
  import ntm_summation_pkg::*;
#(
  parameter int LANE_ID = 0
) (
  input  wire logic      CLK,
  input  wire logic      RST,
  input  wire lane_cmd_t lane_cmd,
  output data_t          sum
);

  ////////////////////////////////////////
  // Constants
  ////////////////////////////////////////

  localparam int MSB = `NTM_DATA_WIDTH - 1;

  // Saturation limits
  localparam data_t DATA_MAX = {1'b0, {MSB{1'b1}}};
  localparam data_t DATA_MIN = {1'b1, {MSB{1'b0}}};

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  logic hit;
  logic signed [`NTM_DATA_WIDTH:0] add_full;
  logic overflow;
  data_t sat_sum;

  // Command addressed to this lane
  assign hit = lane_cmd.valid && (lane_cmd.lane == lane_idx_t'(LANE_ID));

  // One extra bit keeps the true sign
  assign add_full = {sum[MSB], sum} + {lane_cmd.data[MSB], lane_cmd.data};

  // Top two bits differ on overflow
  assign overflow = add_full[MSB+1] ^ add_full[MSB];

  // True sign picks the clamp direction
  assign sat_sum = overflow ? (add_full[MSB+1] ? DATA_MIN : DATA_MAX)
                            : add_full[MSB:0];

  ////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum <= '0;
    end else if (hit) begin
      // First vector loads, later vectors add
      sum <= lane_cmd.clear ? lane_cmd.data : sat_sum;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Adding a same-signed element never flips the sign of the sum
  a_no_wrap : assert property (
    @(posedge CLK) disable iff (RST)
    (hit && !lane_cmd.clear && (sum[MSB] == lane_cmd.data[MSB]))
      |=> (sum[MSB] == $past(sum[MSB]))
  );

endmodule

`default_nettype wire

/* hdl/ntm_summation_macros.svh */
// Width and lane-count macros for the vector summation unit, included by files that size logic
`ifndef NTM_SUMMATION_MACROS_SVH
`define NTM_SUMMATION_MACROS_SVH

////////////////////////////////////////
// Data path
////////////////////////////////////////

// Signed fixed-point element width
`define NTM_DATA_WIDTH 16

////////////////////////////////////////
// Control path
////////////////////////////////////////

// Width of SIZE_IN and LENGTH_IN count fields
`define NTM_CTRL_WIDTH 8

// Number of accumulator lanes, also the longest vector accepted
`define NTM_LANES 8

// Bits needed to address one lane
`define NTM_LANE_IDX_WIDTH 3

// NTM_LANE_IDX_WIDTH must cover NTM_LANES-1
// Both are changed together when the lane count moves

`endif

/* hdl/ntm_summation_pkg.sv */
// Shared types of the vector summation unit; imported by every module of the design
`default_nettype none

`include "ntm_summation_macros.svh"

package ntm_summation_pkg;

  ////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////

  // One signed vector element or lane sum
  typedef logic signed [`NTM_DATA_WIDTH-1:0] data_t;

  // Vector count and vector length
  typedef logic [`NTM_CTRL_WIDTH-1:0] count_t;

  // Lane address
  typedef logic [`NTM_LANE_IDX_WIDTH-1:0] lane_idx_t;

  ////////////////////////////////////////
  // Command structs
  ////////////////////////////////////////

  // Element broadcast from dispatcher to all lanes
  typedef struct packed {
    logic      valid;
    logic      clear;   // First vector, load instead of add
    lane_idx_t lane;
    data_t     data;
  } lane_cmd_t;

  // Drain request from dispatcher to collector
  typedef struct packed {
    logic   valid;
    count_t length;
  } drain_cmd_t;

  // Dispatcher FSM
  typedef enum logic {IDLE_STATE, INPUT_STATE} dispatch_state_t;

endpackage

`default_nettype wire

/* hdl/ntm_vector_summation.sv */
// Top level of the streaming vector summation unit; connects dispatcher, lanes and collector
`timescale 1ns/1ns
`default_nettype none

`include "ntm_summation_macros.svh"

module ntm_vector_summation
  import ntm_summation_pkg::*;
(
  // Global
  input  wire logic   CLK,
  input  wire logic   RST,

  // Job control
  input  wire logic   START,
  input  wire count_t SIZE_IN,
  input  wire count_t LENGTH_IN,

  // Element input
  input  wire logic   DATA_IN_ENABLE,
  input  wire data_t  DATA_IN,

  // Result output
  output logic        DATA_OUT_ENABLE,
  output data_t       DATA_OUT,
  output logic        READY,
  output logic        BUSY
);

  ////////////////////////////////////////
  // Internal buses
  ////////////////////////////////////////

  // Element broadcast to every lane
  lane_cmd_t  lane_cmd;

  // Drain trigger
  drain_cmd_t drain;

  // One sum per lane
  data_t      lane_sums [`NTM_LANES];

  ////////////////////////////////////////
  // Dispatcher
  ////////////////////////////////////////

  ntm_summation_dispatcher i_dispatcher (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .size_in        (SIZE_IN),
    .length_in      (LENGTH_IN),
    .data_in_enable (DATA_IN_ENABLE),
    .data_in        (DATA_IN),
    .busy           (BUSY),
    .lane_cmd       (lane_cmd),
    .drain          (drain)
  );

  ////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////

  for (genvar g = 0; g < `NTM_LANES; g++) begin : g_lane
    ntm_summation_lane #(
      .LANE_ID (g)
    ) i_lane (
      .CLK      (CLK),
      .RST      (RST),
      .lane_cmd (lane_cmd),
      .sum      (lane_sums[g])
    );
  end

  ////////////////////////////////////////
  // Collector
  ////////////////////////////////////////

  ntm_summation_collector i_collector (
    .CLK             (CLK),
    .RST             (RST),
    .drain           (drain),
    .lane_sums       (lane_sums),
    .data_out_enable (DATA_OUT_ENABLE),
    .data_out        (DATA_OUT),
    .ready           (READY)
  );

endmodule

`default_nettype wire

/* ntm_vector_summation.f */
+incdir+hdl
hdl/ntm_summation_pkg.sv
hdl/ntm_summation_dispatcher.sv
hdl/ntm_summation_lane.sv
hdl/ntm_summation_collector.sv
hdl/ntm_vector_summation.sv
verification/ntm_vector_summation_tb.sv

/* verification/ntm_vector_summation_tb.sv */
// Testbench for the vector summation unit; runs all jobs against a reference model
`timescale 1ns/1ns
`default_nettype none

`include "ntm_summation_macros.svh"

module ntm_vector_summation_tb
  import ntm_summation_pkg::*;
();

  ////////////////////////////////////////
  // Constants and signals
  ////////////////////////////////////////

  // About 1500 cycles of jobs, plenty of margin
  localparam int MAX_CYCLES = 4000;
  localparam int DATA_MAX = (1 <<< (`NTM_DATA_WIDTH - 1)) - 1;
  localparam int DATA_MIN = -(1 <<< (`NTM_DATA_WIDTH - 1));

  logic   CLK;
  logic   RST;
  logic   START;
  count_t SIZE_IN;
  count_t LENGTH_IN;
  logic   DATA_IN_ENABLE;
  data_t  DATA_IN;
  logic   DATA_OUT_ENABLE;
  data_t  DATA_OUT;
  logic   READY;
  logic   BUSY;

  // Input vectors of the current job, [vector][position]
  data_t vec_mem [`NTM_LANES][`NTM_LANES];

  // Expected outputs and READY flags, in order
  data_t exp_q [$];
  bit    rdy_q [$];

  int cycle_count = 0;
  int last_strobe_cycle = 0;
  int out_total = 0;
  int errors = 0;
  int pass_count = 0;
  int fail_count = 0;
  logic [31:0] rng = 32'h517e;
  logic prev_doe = 1'b0;
  bit   last_exp_ready = 1'b1;

  ntm_vector_summation i_dut (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .SIZE_IN         (SIZE_IN),
    .LENGTH_IN       (LENGTH_IN),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .DATA_IN         (DATA_IN),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT),
    .READY           (READY),
    .BUSY            (BUSY)
  );

  // 20 ns period
  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Load the first vector, then add each later one with clamping
  function automatic data_t ref_sum(input int size, input int pos);
    int acc;
    acc = vec_mem[0][pos];
    for (int v = 1; v < size; v++) begin
      acc = acc + vec_mem[v][pos];
      if (acc > DATA_MAX) acc = DATA_MAX;
      if (acc < DATA_MIN) acc = DATA_MIN;
    end
    return data_t'(acc);
  endfunction

  // Inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic run_job(input int size, input int len, input bit gaps, input bit poke_start);
    int start_total;
    start_total = out_total;
    while (BUSY) next_cycle();
    for (int p = 0; p < len; p++) begin
      exp_q.push_back(ref_sum(size, p));
      rdy_q.push_back(p == len - 1);
    end
    START     = 1'b1;
    SIZE_IN   = count_t'(size);
    LENGTH_IN = count_t'(len);
    next_cycle();
    START = 1'b0;
    if (!BUSY) begin
      $display("BUSY did not rise after an accepted START at %0t", $time);
      errors++;
    end
    for (int v = 0; v < size; v++) begin
      for (int e = 0; e < len; e++) begin
        if (gaps) begin
          rng = xorshift32(rng);
          repeat (rng % 3) next_cycle();
        end
        DATA_IN_ENABLE    = 1'b1;
        DATA_IN           = vec_mem[v][e];
        last_strobe_cycle = cycle_count;
        // Second START mid-job, with another shape
        if (poke_start && v == 0 && e == 1) begin
          START     = 1'b1;
          SIZE_IN   = count_t'(1);
          LENGTH_IN = count_t'(2);
        end
        next_cycle();
        DATA_IN_ENABLE = 1'b0;
        START          = 1'b0;
        if (poke_start && !BUSY) begin
          $display("BUSY dropped after a START during a job at %0t", $time);
          errors++;
        end
      end
    end
    @(negedge CLK);
    while (!READY) @(negedge CLK);
    next_cycle();
    if (out_total - start_total != len) begin
      $display("Fail at %0t: job gave %0d outputs instead of %0d",
               $time, out_total - start_total, len);
      errors++;
    end
    // BUSY ends together with the READY cycle
    if (BUSY) begin
      $display("BUSY still high after the READY cycle at %0t", $time);
      errors++;
    end
  endtask

  // A START that must be refused, then a quiet wait
  task automatic refused_start(input int size, input int len);
    int start_total;
    start_total = out_total;
    START     = 1'b1;
    SIZE_IN   = count_t'(size);
    LENGTH_IN = count_t'(len);
    next_cycle();
    START = 1'b0;
    repeat (8) next_cycle();
    if (BUSY || out_total != start_total) begin
      $display("START with size %0d length %0d was not ignored", size, len);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      pass_count++;
      $display("%s: passed", name);
    end else begin
      fail_count++;
      $display("%s: FAILED with %0d errors", name, errors - errs_before);
    end
  endtask

  ////////////////////////////////////////
  // Output checker and timeout
  ////////////////////////////////////////

  // Sampled at the falling edge, away from input changes
  always @(negedge CLK) begin
    if (!RST) begin
      if (DATA_OUT_ENABLE) begin
        if (!prev_doe && cycle_count - last_strobe_cycle != 3) begin
          $display("Fail at %0t: first output came %0d cycles after last strobe, not 3",
                   $time, cycle_count - last_strobe_cycle);
          errors++;
        end
        if (exp_q.size() == 0) begin
          $display("Output strobe at %0t with no output expected", $time);
          errors++;
        end else begin
          last_exp_ready = rdy_q.pop_front();
          if (DATA_OUT !== exp_q[0]) begin
            $display("Fail at %0t: output %0d is %0d, expected %0d",
                     $time, out_total, DATA_OUT, exp_q[0]);
            errors++;
          end
          void'(exp_q.pop_front());
          if (READY !== last_exp_ready) begin
            $display("Fail at %0t: READY is %b, expected %b", $time, READY, last_exp_ready);
            errors++;
          end
        end
        if (READY && !BUSY) begin
          $display("BUSY fell before the READY cycle at %0t", $time);
          errors++;
        end
        out_total++;
      end else begin
        if (READY) begin
          $display("READY high without an output strobe at %0t", $time);
          errors++;
        end
        if (prev_doe && !last_exp_ready) begin
          $display("Output burst broke off before its last element at %0t", $time);
          errors++;
        end
      end
      prev_doe = DATA_OUT_ENABLE;
    end
  end

  always @(posedge CLK) begin
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display("Test failed");
      $finish;
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int mark;
    int size;
    int len;
    int idle_total;
    RST            = 1'b1;
    START          = 1'b0;
    SIZE_IN        = '0;
    LENGTH_IN      = '0;
    DATA_IN_ENABLE = 1'b0;
    DATA_IN        = '0;
    repeat (5) @(posedge CLK);
    #2;
    RST = 1'b0;

    mark = errors;
    if (READY || DATA_OUT_ENABLE || BUSY) begin
      $display("Outputs not idle right after reset");
      errors++;
    end
    finish_test("Reset state", mark);

    // Small mixed-sign values
    mark = errors;
    for (int v = 0; v < 3; v++) begin
      for (int e = 0; e < 4; e++) vec_mem[v][e] = data_t'(v * 5 - e * 3 + 1);
    end
    run_job(3, 4, 1'b0, 1'b0);
    finish_test("Basic sum", mark);

    mark = errors;
    for (int j = 0; j < 6; j++) begin
      rng  = xorshift32(rng);
      size = 1 + rng % 6;
      rng  = xorshift32(rng);
      len  = 1 + rng % `NTM_LANES;
      for (int v = 0; v < size; v++) begin
        for (int e = 0; e < len; e++) begin
          rng = xorshift32(rng);
          vec_mem[v][e] = data_t'(rng[15:0]);
        end
      end
      run_job(size, len, 1'b1, 1'b0);
    end
    finish_test("Latency and count with gaps", mark);

    // Clamp high, clamp low, and clamping in the middle of a column
    mark = errors;
    for (int v = 0; v < 4; v++) begin
      vec_mem[v][0] = data_t'(25000);
      vec_mem[v][1] = data_t'(-25000);
      vec_mem[v][2] = (v == 0) ? data_t'(DATA_MAX) : data_t'(-100);
      vec_mem[v][3] = (v == 0) ? data_t'(DATA_MIN) : data_t'(7);
    end
    run_job(4, 4, 1'b0, 1'b0);
    finish_test("Saturation", mark);

    mark = errors;
    for (int v = 0; v < 2; v++) begin
      for (int e = 0; e < 5; e++) vec_mem[v][e] = data_t'(1000 * (e + 1));
    end
    run_job(2, 5, 1'b0, 1'b0);
    for (int v = 0; v < 3; v++) begin
      for (int e = 0; e < 5; e++) vec_mem[v][e] = data_t'(e - v);
    end
    run_job(3, 5, 1'b0, 1'b0);
    finish_test("Clearing between jobs", mark);

    mark = errors;
    refused_start(2, 0);
    refused_start(2, `NTM_LANES + 1);
    refused_start(0, 3);
    // Element strobes with no job open
    idle_total     = out_total;
    DATA_IN_ENABLE = 1'b1;
    DATA_IN        = data_t'(123);
    repeat (4) next_cycle();
    DATA_IN_ENABLE = 1'b0;
    repeat (6) next_cycle();
    if (BUSY || out_total != idle_total) begin
      $display("Idle strobes started a job");
      errors++;
    end
    for (int v = 0; v < 2; v++) begin
      for (int e = 0; e < 4; e++) vec_mem[v][e] = data_t'(-7 * e + v);
    end
    run_job(2, 4, 1'b0, 1'b1);
    run_job(2, 4, 1'b1, 1'b0);
    finish_test("Ignored inputs", mark);

    $display("Summary: %0d tests passed, %0d tests with errors", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
